// ==== include/fix_params.svh ====
/*
 * FIX parser parameters.
 * Lane count, tag and value storage sizes and the two delimiter
 * characters of the tag=value<SOH> field format.
 */

`ifndef FIX_PARAMS_SVH
`define FIX_PARAMS_SVH

////////////////////
// Lanes and storage
////////////////////

// Number of field-extraction lanes. Any power of two from 2 up works.
`define FIX_LANES 4

// Storage per field in characters.
`define FIX_TAG_BYTES 4
`define FIX_VALUE_BYTES 32

////////////////////
// Delimiters
////////////////////

`define FIX_CHAR_EQ 8'h3D
`define FIX_CHAR_SOH 8'h01

`endif

// ==== hw/fix_stream_pkg.sv ====
/*
 * FIX byte stream types.
 * A classified byte as it travels from the scanner to a lane.
 */

package fix_stream_pkg;

	// Role of a byte inside a field.
	// KIND_END is the SOH that closes the field.
	typedef enum logic [1:0] {
		KIND_TAG   = 2'd0,
		KIND_VALUE = 2'd1,
		KIND_END   = 2'd2
	} fix_kind_e;

	// One classified byte, 10 bits in all.
	typedef struct packed {
		logic [7:0] data;
		fix_kind_e  kind;
	} fix_char_t;

endpackage

// ==== hw/fix_field_pkg.sv ====
/*
 * FIX extracted field types.
 * The field record handed from a lane to the collector and out of
 * the parser, with its header, trailer and overflow flags.
 */

`include "fix_params.svh"

package fix_field_pkg;

	// Value length counts 0 up to the full value storage.
	typedef logic [$clog2(`FIX_VALUE_BYTES + 1) - 1:0] fix_len_t;

	// Tag and value are packed with the first character in the low byte.
	// Bytes past the end of the text are zero.
	typedef struct packed {
		logic [`FIX_TAG_BYTES * 8 - 1:0]   tag;
		logic [`FIX_VALUE_BYTES * 8 - 1:0] value;
		fix_len_t                          value_len;
		// Tag was "8" (BeginString).
		logic                              start_of_header;
		// Tag was "10" (CheckSum).
		logic                              end_of_body;
		// Tag or value ran past its storage.
		logic                              overflow;
	} fix_field_t;

endpackage

// ==== hw/fix_byte_scanner.sv ====
/*
 * FIX byte scanner.
 * Accepts bytes over a four-phase req/ack port, classifies each one as
 * tag, value or field end, and routes it round-robin to the lanes.
 */

`timescale 1ns/1ps
`include "fix_params.svh"

module fix_byte_scanner (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_req_i,
	input  logic [7:0]                 in_byte_i,
	input  logic [`FIX_LANES-1:0]      lane_busy_i,
	output logic                       in_ack_o,
	output logic [`FIX_LANES-1:0]      char_valid_o,
	output fix_stream_pkg::fix_char_t  char_o
);
	import fix_stream_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_SEND, S_ACK} scan_state_e;

	scan_state_e                    state;
	logic                           req_meta;
	logic                           req_sync;
	logic                           in_tag_q;
	logic                           field_open_q;
	logic [$clog2(`FIX_LANES)-1:0]  lane_ptr;
	logic                           is_soh;
	logic                           is_eq;
	logic                           hold_byte;

	assign is_soh = (in_byte_i == `FIX_CHAR_SOH);
	// Only the first "=" of a field is a delimiter; later ones are value text.
	assign is_eq = in_tag_q && (in_byte_i == `FIX_CHAR_EQ);
	// A new field may only start in a lane that has been drained.
	assign hold_byte = !field_open_q && lane_busy_i[lane_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			req_meta <= 1'b0;
			req_sync <= 1'b0;
		end else begin
			req_meta <= in_req_i;
			req_sync <= req_meta;
		end
	end

	////////////////////
	// Four-phase acceptor
	////////////////////

	always_ff @(posedge clk) begin
		char_valid_o <= '0;
		if (rst) begin
			state        <= S_IDLE;
			in_ack_o     <= 1'b0;
			in_tag_q     <= 1'b1;
			field_open_q <= 1'b0;
			lane_ptr     <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_sync) begin
						state <= S_SEND;
					end
				end
				S_SEND: begin
					if (!hold_byte) begin
						in_ack_o <= 1'b1;
						state    <= S_ACK;
						if (is_soh) begin
							char_valid_o[lane_ptr] <= 1'b1;
							lane_ptr               <= lane_ptr + 1'b1;
							in_tag_q               <= 1'b1;
							field_open_q           <= 1'b0;
						end else if (is_eq) begin
							// The delimiter itself never reaches the lane.
							in_tag_q     <= 1'b0;
							field_open_q <= 1'b1;
						end else begin
							char_valid_o[lane_ptr] <= 1'b1;
							field_open_q           <= 1'b1;
						end
					end
				end
				S_ACK: begin
					if (!req_sync) begin
						in_ack_o <= 1'b0;
						state    <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_SEND) begin
			char_o.data <= in_byte_i;
			if (is_soh) begin
				char_o.kind <= KIND_END;
			end else if (in_tag_q) begin
				char_o.kind <= KIND_TAG;
			end else begin
				char_o.kind <= KIND_VALUE;
			end
		end
	end

endmodule

// ==== hw/fix_field_extract.sv ====
/*
 * FIX field extraction lane.
 * Packs the tag and value characters of one field, flags BeginString,
 * CheckSum and overflow, and holds the result until it is taken.
 */

`timescale 1ns/1ps
`include "fix_params.svh"

module fix_field_extract (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       char_valid_i,
	input  fix_stream_pkg::fix_char_t  char_i,
	input  logic                       take_i,
	output logic                       busy_o,
	output logic                       field_valid_o,
	output fix_field_pkg::fix_field_t  field_o
);
	import fix_stream_pkg::*;
	import fix_field_pkg::*;

	// Tags that mark the message boundaries, first character low.
	localparam logic [`FIX_TAG_BYTES*8-1:0] tag_begin_string = 'h38;
	localparam logic [`FIX_TAG_BYTES*8-1:0] tag_check_sum    = 'h3031;

	fix_field_t                           field_q;
	logic [$clog2(`FIX_TAG_BYTES+1)-1:0]  tag_cnt;
	logic                                 active_q;
	logic                                 valid_q;

	////////////////////
	// Field assembly
	////////////////////

	// Clearing on take also zeroes the unused bytes for the next field.
	always_ff @(posedge clk) begin
		if (rst || take_i) begin
			field_q  <= '0;
			tag_cnt  <= '0;
			active_q <= 1'b0;
			valid_q  <= 1'b0;
		end else if (char_valid_i && !valid_q) begin
			active_q <= 1'b1;
			case (char_i.kind)
				KIND_TAG: begin
					if (tag_cnt < `FIX_TAG_BYTES) begin
						field_q.tag[tag_cnt*8 +: 8] <= char_i.data;
						tag_cnt                     <= tag_cnt + 1'b1;
					end else begin
						field_q.overflow <= 1'b1;
					end
				end
				KIND_VALUE: begin
					if (field_q.value_len < `FIX_VALUE_BYTES) begin
						field_q.value[field_q.value_len*8 +: 8] <= char_i.data;
						field_q.value_len <= field_q.value_len + 1'b1;
					end else begin
						field_q.overflow <= 1'b1;
					end
				end
				KIND_END: begin
					// An overflowed tag holds four characters and matches neither.
					field_q.start_of_header <= (field_q.tag == tag_begin_string);
					field_q.end_of_body     <= (field_q.tag == tag_check_sum);
					valid_q                 <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Busy from the first character until the collector takes the field.
	assign busy_o        = active_q | valid_q;
	assign field_valid_o = valid_q;
	assign field_o       = field_q;

endmodule

// ==== hw/fix_field_collect.sv ====
/*
 * FIX field collector.
 * Drains finished fields from the lanes in arrival order and sends
 * them one at a time over a four-phase req/ack port.
 */

`timescale 1ns/1ps
`include "fix_params.svh"

module fix_field_collect (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`FIX_LANES-1:0]      field_valid_i,
	input  fix_field_pkg::fix_field_t  fields_i [`FIX_LANES],
	input  logic                       out_ack_i,
	output logic [`FIX_LANES-1:0]      take_o,
	output logic                       out_req_o,
	output fix_field_pkg::fix_field_t  field_o
);
	import fix_field_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_RELEASE} out_state_e;

	out_state_e                     state;
	logic                           ack_meta;
	logic                           ack_sync;
	logic [$clog2(`FIX_LANES)-1:0]  rd_ptr;
	fix_field_t                     field_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
		end else begin
			ack_meta <= out_ack_i;
			ack_sync <= ack_meta;
		end
	end

	////////////////////
	// Four-phase sender
	////////////////////

	// The read pointer follows the scanner's lane order, so fields
	// leave in the order they arrived.
	always_ff @(posedge clk) begin
		take_o <= '0;
		if (rst) begin
			state     <= S_IDLE;
			out_req_o <= 1'b0;
			rd_ptr    <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (field_valid_i[rd_ptr]) begin
						take_o[rd_ptr] <= 1'b1;
						out_req_o      <= 1'b1;
						state          <= S_REQ;
					end
				end
				S_REQ: begin
					if (ack_sync) begin
						out_req_o <= 1'b0;
						state     <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!ack_sync) begin
						rd_ptr <= rd_ptr + 1'b1;
						state  <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Output register, stable until the next field is latched.
	always_ff @(posedge clk) begin
		if (state == S_IDLE && field_valid_i[rd_ptr]) begin
			field_q <= fields_i[rd_ptr];
		end
	end

	assign field_o = field_q;

endmodule

// ==== hw/fix_parser_top.sv ====
/*
 * FIX field parser top level.
 * Scanner, a bank of extraction lanes and the output collector.
 */

`timescale 1ns/1ps
`include "fix_params.svh"

module fix_parser_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_req_i,
	input  logic [7:0]                 in_byte_i,
	output logic                       in_ack_o,
	output logic                       out_req_o,
	input  logic                       out_ack_i,
	output fix_field_pkg::fix_field_t  field_o
);
	import fix_stream_pkg::*;
	import fix_field_pkg::*;

	logic [`FIX_LANES-1:0]  lane_busy;
	logic [`FIX_LANES-1:0]  char_valid;
	fix_char_t              char_bus;
	logic [`FIX_LANES-1:0]  field_valid;
	logic [`FIX_LANES-1:0]  take;
	fix_field_t             lane_fields [`FIX_LANES];

	fix_byte_scanner scanner_i (
		.clk          (clk),
		.rst          (rst),
		.in_req_i     (in_req_i),
		.in_byte_i    (in_byte_i),
		.lane_busy_i  (lane_busy),
		.in_ack_o     (in_ack_o),
		.char_valid_o (char_valid),
		.char_o       (char_bus)
	);

	// All lanes share the character bus; char_valid selects the target.
	for (genvar g = 0; g < `FIX_LANES; g++) begin : lane_g
		fix_field_extract lane_i (
			.clk           (clk),
			.rst           (rst),
			.char_valid_i  (char_valid[g]),
			.char_i        (char_bus),
			.take_i        (take[g]),
			.busy_o        (lane_busy[g]),
			.field_valid_o (field_valid[g]),
			.field_o       (lane_fields[g])
		);
	end

	fix_field_collect collect_i (
		.clk           (clk),
		.rst           (rst),
		.field_valid_i (field_valid),
		.fields_i      (lane_fields),
		.out_ack_i     (out_ack_i),
		.take_o        (take),
		.out_req_o     (out_req_o),
		.field_o       (field_o)
	);

endmodule

// ==== verification/fix_parser_tb.sv ====
/*
 * Testbench for the FIX field parser.
 * Replays stimulus bytes and expected fields from the golden file, runs
 * both four-phase handshakes and checks every field that comes out.
 */

`timescale 1ns/1ps

module fix_parser_tb;
	import fix_field_pkg::*;

	logic        clk;
	logic        rst;
	logic        in_req;
	logic [7:0]  in_byte;
	logic        in_ack;
	logic        out_req;
	logic        out_ack;
	fix_field_t  field_out;

	logic [7:0]  stim_bytes [$];
	fix_field_t  exp_fields [$];
	int          exp_delay [$];
	int          cur_delay;
	int          rx_count;
	int          watch_cycles;
	integer      seed = 32'h2faf536f;
	logic        load_ok;
	logic        run_start = 1'b0;
	logic        drive_done = 1'b0;
	int          field_errors = 0;
	int          count_errors = 0;
	int          level_errors = 0;
	int          other_errors = 0;

	fix_parser_top dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_req_i  (in_req),
		.in_byte_i (in_byte),
		.in_ack_o  (in_ack),
		.out_req_o (out_req),
		.out_ack_i (out_ack),
		.field_o   (field_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// Compare tasks
	////////////////////

	task check_field(input int idx, input fix_field_t got, input fix_field_t exp);
		if (got.tag !== exp.tag) begin
			$display("** Error field[%0d].tag: got %h, expected %h", idx, got.tag, exp.tag);
			field_errors++;
		end
		if (got.value !== exp.value) begin
			$display("** Error field[%0d].value: got %h, expected %h", idx, got.value,
				exp.value);
			field_errors++;
		end
		if (got.value_len !== exp.value_len) begin
			$display("** Error field[%0d].value_len: got %h, expected %h", idx,
				got.value_len, exp.value_len);
			field_errors++;
		end
		if ({got.start_of_header, got.end_of_body, got.overflow} !==
		    {exp.start_of_header, exp.end_of_body, exp.overflow}) begin
			$display("** Error field[%0d].flags: got %h, expected %h", idx,
				{got.start_of_header, got.end_of_body, got.overflow},
				{exp.start_of_header, exp.end_of_body, exp.overflow});
			field_errors++;
		end
	endtask

	task check_count(input int got, input int exp);
		if (got != exp) begin
			$display("** Error field count: got %h, expected %h", got, exp);
			count_errors++;
		end
	endtask

	task check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error %s: got %h, expected %h", name, got, exp);
			level_errors++;
		end
	endtask

	////////////////////
	// Golden file
	////////////////////

	// Records are B (bytes), F (expected field) and D (max ack delay).
	task load_golden();
		integer            fd;
		integer            code;
		int                n;
		int                i;
		logic [7:0]        kind_ch;
		logic [7:0]        b;
		logic [31:0]       tag;
		logic [255:0]      value;
		fix_len_t          len;
		logic [2:0]        flags;
		logic [8*128-1:0]  skip_line;
		fix_field_t        f;
		load_ok = 1'b1;
		cur_delay = 0;
		fd = $fopen("verification/fix_parser_golden.txt", "r");
		if (fd == 0) begin
			$display("Error: could not open the golden file.");
			other_errors++;
			load_ok = 1'b0;
		end else begin
			while ($fscanf(fd, " %c", kind_ch) == 1) begin
				case (kind_ch)
					"#": code = $fgets(skip_line, fd);
					"B": begin
						code = $fscanf(fd, " %d", n);
						for (i = 0; i < n; i++) begin
							code = $fscanf(fd, " %h", b);
							stim_bytes.push_back(b);
						end
					end
					"F": begin
						code = $fscanf(fd, " %h %h %h %h", tag, value, len, flags);
						if (code != 4) begin
							$display("Error: a field record in the golden file is malformed.");
							other_errors++;
						end
						f.tag             = tag;
						f.value           = value;
						f.value_len       = len;
						f.start_of_header = flags[2];
						f.end_of_body     = flags[1];
						f.overflow        = flags[0];
						exp_fields.push_back(f);
						exp_delay.push_back(cur_delay);
					end
					"D": code = $fscanf(fd, " %d", cur_delay);
					default: begin
						$display("Error: the golden file holds an unknown record type.");
						other_errors++;
					end
				endcase
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// Input driver
	////////////////////

	initial begin : drive_bytes
		int i;
		wait (run_start);
		for (i = 0; i < stim_bytes.size(); i++) begin
			@(negedge clk);
			in_byte = stim_bytes[i];
			in_req  = 1'b1;
			@(negedge clk);
			while (!in_ack) @(negedge clk);
			in_req = 1'b0;
			while (in_ack) @(negedge clk);
		end
		drive_done = 1'b1;
	end

	// Answers out_req with a random ack delay bounded by the D record in force.
	initial begin : receive_fields
		int max_delay;
		int delay;
		wait (run_start);
		forever begin
			@(negedge clk);
			if (out_req) begin
				if (rx_count < exp_fields.size()) begin
					check_field(rx_count, field_out, exp_fields[rx_count]);
					max_delay = exp_delay[rx_count];
				end else begin
					$display("Error: the DUT sent more fields than the %0d expected.",
						exp_fields.size());
					other_errors++;
					max_delay = 0;
				end
				delay = $unsigned($random(seed)) % (max_delay + 1);
				repeat (delay) @(negedge clk);
				out_ack = 1'b1;
				while (out_req) @(negedge clk);
				delay = $unsigned($random(seed)) % (max_delay + 1);
				repeat (delay) @(negedge clk);
				out_ack = 1'b0;
				rx_count++;
			end
		end
	end

	initial begin : watchdog
		wait (run_start);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", watch_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main_seq
		int total;
		rst      = 1'b1;
		in_req   = 1'b0;
		in_byte  = 8'h00;
		out_ack  = 1'b0;
		rx_count = 0;
		load_golden();
		watch_cycles = (stim_bytes.size() + exp_fields.size()) * 200;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_level("in_ack_o", in_ack, 1'b0);
		check_level("out_req_o", out_req, 1'b0);
		if (load_ok) begin
			run_start = 1'b1;
			while (!(drive_done && rx_count == exp_fields.size())) @(negedge clk);
			// Idle time so that a duplicated field would still show up.
			repeat (100) @(negedge clk);
			check_count(rx_count, exp_fields.size());
			check_level("in_ack_o", in_ack, 1'b0);
			check_level("out_req_o", out_req, 1'b0);
		end
		total = field_errors + count_errors + level_errors + other_errors;
		$display("Errors: field %0d, count %0d, level %0d, other %0d", field_errors,
			count_errors, level_errors, other_errors);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== verification/fix_parser_golden.txt ====
# B <count> <bytes, hex> | F <tag> <value> <value_len> <flags>, hex, first char in low byte
# flags = {start_of_header, end_of_body, overflow} | D <max ack delay in cycles, decimal>
D 4
B 10 38 3D 46 49 58 2E 34 2E 32 01
F 38 322E342E584946 7 4
B 5 39 3D 36 35 01
F 39 3536 2 0
B 5 33 35 3D 41 01
F 3533 41 1 0
B 7 34 39 3D 53 52 56 01
F 3934 565253 3 0
B 7 31 30 3D 31 32 33 01
F 3031 333231 3 2
B 7 35 38 3D 61 3D 62 01
F 3835 623D61 3 0
B 4 35 35 3D 01
F 3535 0 0 0
B 20 35 38 3D 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51
B 17 52 53 54 55 56 57 58 59 5A 30 31 32 33 34 35 36 01
F 3835 3534333231305A595857565554535251504F4E4D4C4B4A494847464544434241 20 1
B 8 31 32 33 34 35 3D 58 01
F 34333231 58 1 1
B 6 31 31 3D 6F 6B 01
F 3131 6B6F 2 0
D 150
B 10 38 3D 46 49 58 2E 34 2E 34 01
F 38 342E342E584946 7 4
B 5 33 35 3D 30 01
F 3533 30 1 0
B 5 33 34 3D 37 01
F 3433 37 1 0
B 7 31 30 3D 32 30 30 01
F 3031 303032 3 2

// ==== fix_parser.f ====
+incdir+include
hw/fix_stream_pkg.sv
hw/fix_field_pkg.sv
hw/fix_byte_scanner.sv
hw/fix_field_extract.sv
hw/fix_field_collect.sv
hw/fix_parser_top.sv
verification/fix_parser_tb.sv
